// ==== Bender.yml ====
package:
  name: axi_burst_master

sources:
  - files:
      - design/axi_burst_pkg.sv
      - design/burst_cmd_if.sv
      - design/burst_request_capture.sv
      - design/axi_read_engine.sv
      - design/axi_write_engine.sv
      - design/axi_burst_master.sv
  - target: test
    files:
      - verification/axi_mem_model.sv
      - verification/axi_burst_master_tb.sv

// ==== design/axi_burst_master.sv ====
/*
 * AXI4 burst master for the vector load/store unit
 * Request capture plus read and write engines on plain AXI4 ports
 */
`timescale 1ns/1ns
`default_nettype none

module axi_burst_master import axi_burst_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    // Load/store unit requests
    input  logic        ld_req,
    input  logic        st_req,
    input  addr_t       base_addr,
    input  axi_len_t    burst_len,
    input  burst_data_t vlsu_wdata,
    input  burst_strb_t write_strobe,
    output logic        busy,
    // Load/store unit completions
    output burst_data_t burst_rdata,
    output logic        burst_valid_data,
    output logic        burst_wr_valid,
    // AR channel
    output logic        arvalid,
    input  logic        arready,
    output axi_id_t     arid,
    output addr_t       araddr,
    output axi_len_t    arlen,
    // R channel
    input  logic        rvalid,
    output logic        rready,
    input  axi_id_t     rid,
    input  data_t       rdata,
    input  axi_resp_t   rresp,
    input  logic        rlast,
    // AW channel
    output logic        awvalid,
    input  logic        awready,
    output axi_id_t     awid,
    output addr_t       awaddr,
    output axi_len_t    awlen,
    // W channel
    output logic        wvalid,
    input  logic        wready,
    output data_t       wdata,
    output strb_t       wstrb,
    output logic        wlast,
    // B channel
    input  logic        bvalid,
    output logic        bready,
    input  axi_id_t     bid,
    input  axi_resp_t   bresp
);

    // Shared command and completion bus
    burst_cmd_if cmd_bus ();

    // ========================================================================
    // Input side
    // ========================================================================

    burst_request_capture u_capture (
        .clk          (clk),
        .reset        (reset),
        .ld_req       (ld_req),
        .st_req       (st_req),
        .base_addr    (base_addr),
        .burst_len    (burst_len),
        .vlsu_wdata   (vlsu_wdata),
        .write_strobe (write_strobe),
        .busy         (busy),
        .cmd          (cmd_bus.capture)
    );

    // ========================================================================
    // Engines
    // ========================================================================

    axi_read_engine u_rd_engine (
        .clk              (clk),
        .reset            (reset),
        .arvalid          (arvalid),
        .arready          (arready),
        .arid             (arid),
        .araddr           (araddr),
        .arlen            (arlen),
        .rvalid           (rvalid),
        .rready           (rready),
        .rid              (rid),
        .rdata            (rdata),
        .rresp            (rresp),
        .rlast            (rlast),
        .burst_rdata      (burst_rdata),
        .burst_valid_data (burst_valid_data),
        .cmd              (cmd_bus.rd_engine)
    );

    axi_write_engine u_wr_engine (
        .clk            (clk),
        .reset          (reset),
        .awvalid        (awvalid),
        .awready        (awready),
        .awid           (awid),
        .awaddr         (awaddr),
        .awlen          (awlen),
        .wvalid         (wvalid),
        .wready         (wready),
        .wdata          (wdata),
        .wstrb          (wstrb),
        .wlast          (wlast),
        .bvalid         (bvalid),
        .bready         (bready),
        .bid            (bid),
        .bresp          (bresp),
        .burst_wr_valid (burst_wr_valid),
        .cmd            (cmd_bus.wr_engine)
    );

endmodule

`default_nettype wire

// ==== design/axi_burst_pkg.sv ====
/*
 * AXI4 burst master shared definitions
 * Bus widths, burst limits, response codes and FSM state types
 */
`default_nettype none

package axi_burst_pkg;

    // ========================================================================
    // Bus and burst geometry
    // ========================================================================

    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 32;
    // Bytes per beat, one strobe bit each
    localparam int STRB_W    = DATA_W / 8;
    localparam int ID_W      = 4;
    // Largest burst the load/store unit hands over
    localparam int BURST_MAX = 4;
    localparam int LEN_W     = 8;

    // AXI response codes that the master tells apart
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // ========================================================================
    // Vector types
    // ========================================================================

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [ID_W-1:0]   axi_id_t;
    // Beats minus one, as on AxLEN
    typedef logic [LEN_W-1:0]  axi_len_t;
    typedef logic [1:0]        axi_resp_t;

    // Whole burst packed, beat 0 in the low word
    typedef logic [DATA_W*BURST_MAX-1:0] burst_data_t;
    typedef logic [STRB_W*BURST_MAX-1:0] burst_strb_t;

    // Beat counter, wide enough for BURST_MAX beats
    typedef logic [$clog2(BURST_MAX)-1:0] beat_idx_t;

    // Read engine FSM
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_t;

    // Write engine FSM
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_t;

endpackage

`default_nettype wire

// ==== design/axi_read_engine.sv ====
/*
 * AXI4 read engine
 * Issues the AR burst, packs R beats into one block and checks responses
 */
`timescale 1ns/1ns
`default_nettype none

module axi_read_engine import axi_burst_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    // AR channel
    output logic        arvalid,
    input  logic        arready,
    output axi_id_t     arid,
    output addr_t       araddr,
    output axi_len_t    arlen,
    // R channel
    input  logic        rvalid,
    output logic        rready,
    input  axi_id_t     rid,
    input  data_t       rdata,
    input  axi_resp_t   rresp,
    input  logic        rlast,
    // Completed load towards the unit
    output burst_data_t burst_rdata,
    output logic        burst_valid_data,
    // Command bus
    burst_cmd_if.rd_engine cmd
);

    rd_state_t state;
    // Slot of the next matching beat
    beat_idx_t beat_idx;
    // Set by any non-OKAY beat of the current burst
    logic      rd_err;
    // Beat that belongs to this burst
    logic      beat_hit;
    logic      done_q;
    logic      retry_q;

    // Address channel payload comes straight from the held command
    assign arid    = cmd.id;
    assign araddr  = cmd.addr;
    assign arlen   = cmd.len;
    assign arvalid = (state == RD_ADDR);
    // Ready for the whole data phase
    assign rready  = (state == RD_DATA);

    assign beat_hit = rvalid && rready && (rid == cmd.id);

    // ========================================================================
    // FSM
    // ========================================================================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state    <= RD_IDLE;
            beat_idx <= '0;
            rd_err   <= 1'b0;
            done_q   <= 1'b0;
            retry_q  <= 1'b0;
        end else begin
            done_q  <= 1'b0;
            retry_q <= 1'b0;
            case (state)
                RD_IDLE: begin
                    if (cmd.rd_start) begin
                        state    <= RD_ADDR;
                        beat_idx <= '0;
                        rd_err   <= 1'b0;
                    end
                end
                RD_ADDR: begin
                    if (arready) begin
                        state <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (beat_hit) begin
                        beat_idx <= beat_idx + 1'b1;
                        if (rresp != RESP_OKAY) begin
                            rd_err <= 1'b1;
                        end
                        // Outcome includes the last beat's own response
                        if (rlast) begin
                            state   <= RD_IDLE;
                            done_q  <= !rd_err && (rresp == RESP_OKAY);
                            retry_q <= rd_err || (rresp != RESP_OKAY);
                        end
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // Only OKAY beats land in the block, which keeps its value afterwards
    always_ff @(posedge clk) begin
        if (beat_hit && (rresp == RESP_OKAY)) begin
            burst_rdata[beat_idx*DATA_W +: DATA_W] <= rdata;
        end
    end

    assign cmd.rd_done      = done_q;
    assign cmd.rd_retry     = retry_q;
    assign burst_valid_data = done_q;

    // AR valid and its payload held until the slave takes them
    a_ar_hold: assert property (
        @(posedge clk) disable iff (!reset)
        (arvalid && !arready) |=> (arvalid && $stable({arid, araddr, arlen}))
    );

endmodule

`default_nettype wire

// ==== design/axi_write_engine.sv ====
/*
 * AXI4 write engine
 * Sends the AW burst, steps through the W beats and checks the B response
 */
`timescale 1ns/1ns
`default_nettype none

module axi_write_engine import axi_burst_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    // AW channel
    output logic      awvalid,
    input  logic      awready,
    output axi_id_t   awid,
    output addr_t     awaddr,
    output axi_len_t  awlen,
    // W channel
    output logic      wvalid,
    input  logic      wready,
    output data_t     wdata,
    output strb_t     wstrb,
    output logic      wlast,
    // B channel
    input  logic      bvalid,
    output logic      bready,
    input  axi_id_t   bid,
    input  axi_resp_t bresp,
    // Completed store towards the unit
    output logic      burst_wr_valid,
    // Command bus
    burst_cmd_if.wr_engine cmd
);

    wr_state_t state;
    // Beat currently on the W channel
    beat_idx_t beat_cnt;
    // Response that belongs to this burst
    logic      resp_hit;
    logic      done_q;
    logic      retry_q;

    // ========================================================================
    // Channel outputs
    // ========================================================================

    assign awid    = cmd.id;
    assign awaddr  = cmd.addr;
    assign awlen   = cmd.len;
    assign awvalid = (state == WR_ADDR);

    assign wvalid = (state == WR_DATA);
    // Word and strobes picked out of the packed command by beat
    assign wdata  = cmd.wdata[beat_cnt*DATA_W +: DATA_W];
    assign wstrb  = cmd.wstrb[beat_cnt*STRB_W +: STRB_W];
    // Last beat is beat number len
    assign wlast  = wvalid && (axi_len_t'(beat_cnt) == cmd.len);

    // Waiting on the response once all beats are out
    assign bready   = (state == WR_RESP);
    assign resp_hit = bvalid && bready && (bid == cmd.id);

    // ========================================================================
    // FSM
    // ========================================================================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state    <= WR_IDLE;
            beat_cnt <= '0;
            done_q   <= 1'b0;
            retry_q  <= 1'b0;
        end else begin
            done_q  <= 1'b0;
            retry_q <= 1'b0;
            case (state)
                WR_IDLE: begin
                    if (cmd.wr_start) begin
                        state    <= WR_ADDR;
                        beat_cnt <= '0;
                    end
                end
                WR_ADDR: begin
                    if (awready) begin
                        state <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    // Each beat held until the slave takes it
                    if (wready) begin
                        if (wlast) begin
                            state <= WR_RESP;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                WR_RESP: begin
                    // Foreign IDs are drained and ignored
                    if (resp_hit) begin
                        state   <= WR_IDLE;
                        done_q  <= (bresp == RESP_OKAY);
                        retry_q <= (bresp != RESP_OKAY);
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    assign cmd.wr_done    = done_q;
    assign cmd.wr_retry   = retry_q;
    assign burst_wr_valid = done_q;

    // W valid and the beat's payload held until the slave takes the beat
    a_w_hold: assert property (
        @(posedge clk) disable iff (!reset)
        (wvalid && !wready) |=> (wvalid && $stable({wdata, wstrb, wlast}))
    );

endmodule

`default_nettype wire

// ==== design/burst_cmd_if.sv ====
/*
 * Burst command bus between the request capture and the AXI engines
 */
`timescale 1ns/1ns
`default_nettype none

interface burst_cmd_if import axi_burst_pkg::*; ();

    // Start pulses, one per issue of a burst
    logic        rd_start;
    logic        wr_start;
    // Command fields, stable for the whole burst and its retries
    addr_t       addr;
    axi_len_t    len;
    axi_id_t     id;
    burst_data_t wdata;
    burst_strb_t wstrb;
    // Completion pulses back from the engines
    logic        rd_done;
    logic        rd_retry;
    logic        wr_done;
    logic        wr_retry;

    modport capture (
        output rd_start, wr_start, addr, len, id, wdata, wstrb,
        input  rd_done, rd_retry, wr_done, wr_retry
    );

    modport rd_engine (
        input  rd_start, addr, len, id,
        output rd_done, rd_retry
    );

    modport wr_engine (
        input  wr_start, addr, len, id, wdata, wstrb,
        output wr_done, wr_retry
    );

endinterface

`default_nettype wire

// ==== design/burst_request_capture.sv ====
/*
 * Request capture for the burst master
 * Latches a load or store, hands out IDs and restarts a burst on retry
 */
`timescale 1ns/1ns
`default_nettype none

module burst_request_capture import axi_burst_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    // Load/store unit side
    input  logic        ld_req,
    input  logic        st_req,
    input  addr_t       base_addr,
    input  axi_len_t    burst_len,
    input  burst_data_t vlsu_wdata,
    input  burst_strb_t write_strobe,
    output logic        busy,
    // Command bus to the engines
    burst_cmd_if.capture cmd
);

    // New request taken only while no burst is in flight
    logic    accept;
    // Next ID to hand out
    axi_id_t id_cnt;

    assign accept = (ld_req || st_req) && !busy;

    // ========================================================================
    // Transaction ID counter
    // ========================================================================

    // Wraps at 16, retries leave it alone
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            id_cnt <= '0;
        end else if (accept) begin
            id_cnt <= id_cnt + 1'b1;
        end
    end

    // ========================================================================
    // Command fields
    // ========================================================================

    // Same registers serve as the reissue copy
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd.addr  <= base_addr;
            cmd.len   <= burst_len;
            cmd.id    <= id_cnt;
            cmd.wdata <= vlsu_wdata;
            cmd.wstrb <= write_strobe;
        end
    end

    // ========================================================================
    // Start pulses and busy
    // ========================================================================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            busy         <= 1'b0;
            cmd.rd_start <= 1'b0;
            cmd.wr_start <= 1'b0;
        end else begin
            // Fresh request or reissue of the saved one
            cmd.rd_start <= (accept && ld_req) || cmd.rd_retry;
            cmd.wr_start <= (accept && st_req && !ld_req) || cmd.wr_retry;
            if (accept) begin
                busy <= 1'b1;
            end else if (cmd.rd_done || cmd.wr_done) begin
                busy <= 1'b0;
            end
        end
    end

    // Load and store never requested in the same cycle
    a_one_req: assert property (
        @(posedge clk) disable iff (!reset)
        !(ld_req && st_req)
    );

    // Requested burst fits in the packed block
    a_len_fits: assert property (
        @(posedge clk) disable iff (!reset)
        (ld_req || st_req) |-> (burst_len < BURST_MAX)
    );

endmodule

`default_nettype wire

// ==== verification/axi_burst_master_tb.sv ====
/*
 * Testbench for the AXI4 burst master
 * Table of loads and stores against a memory model and a shadow memory
 */
`timescale 1ns/1ns
`default_nettype none

module axi_burst_master_tb import axi_burst_pkg::*; ();

    localparam int DRIVE_DLY   = 2;
    localparam int MEM_WORDS   = 64;
    localparam int NUM_ENTRIES = 9;
    localparam int CYCLE_LIMIT = 200 * NUM_ENTRIES + 50;

    logic        clk;
    logic        reset;
    logic        ld_req, st_req, arm_error;
    addr_t       base_addr;
    axi_len_t    burst_len;
    burst_data_t vlsu_wdata;
    burst_strb_t write_strobe;
    logic        busy;
    burst_data_t burst_rdata;
    logic        burst_valid_data, burst_wr_valid;
    logic        arvalid, arready, rvalid, rready, rlast;
    axi_id_t     arid, rid, awid, bid;
    addr_t       araddr, awaddr;
    axi_len_t    arlen, awlen;
    data_t       rdata, wdata;
    axi_resp_t   rresp, bresp;
    logic        awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    strb_t       wstrb;

    // Stimulus table
    logic        t_store  [NUM_ENTRIES];
    addr_t       t_addr   [NUM_ENTRIES];
    axi_len_t    t_len    [NUM_ENTRIES];
    burst_data_t t_wdata  [NUM_ENTRIES];
    burst_strb_t t_wstrb  [NUM_ENTRIES];
    logic        t_inject [NUM_ENTRIES];
    logic        t_dup    [NUM_ENTRIES];
    int          n_entries;

    // Reference state
    data_t   shadow [MEM_WORDS];
    axi_id_t exp_id;
    int      errors, checks, cycle_cnt;

    // Monitor results for the current entry
    addr_t    hs_addr[$];
    axi_len_t hs_len[$];
    axi_id_t  hs_id[$];
    int       w_beats, wlast_cnt, wlast_bad, w_pos, cur_len;
    int       rd_done_cnt, wr_done_cnt;

    axi_burst_master uut (.*);

    axi_mem_model #(.MEM_WORDS(MEM_WORDS)) u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ========================================================================
    // Helpers
    // ========================================================================

    task automatic check_value(string name, logic [127:0] actual, logic [127:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t: %s actual %0h expected %0h",
                     $time, name, actual, expected);
        end
    endtask

    // Initial memory word, spread over every address bit
    function automatic data_t fill_word(int idx);
        addr_t a;
        a = addr_t'(idx * 4);
        return (a * 32'h9e37_79b9) ^ 32'h5a5a_5a5a;
    endfunction

    function automatic int shadow_index(addr_t a);
        return (a >> 2) % MEM_WORDS;
    endfunction

    task automatic add_entry(logic st, addr_t a, axi_len_t len, burst_data_t d,
                             burst_strb_t s, logic inj, logic dup);
        t_store[n_entries]  = st;
        t_addr[n_entries]   = a;
        t_len[n_entries]    = len;
        t_wdata[n_entries]  = d;
        t_wstrb[n_entries]  = s;
        t_inject[n_entries] = inj;
        t_dup[n_entries]    = dup;
        n_entries++;
    endtask

    task automatic load_table();
        n_entries = 0;
        // Full store then read back
        add_entry(1, 32'h10, 3, 128'h4444_4444_3333_3333_2222_2222_1111_1111, 16'hffff, 0, 0);
        add_entry(0, 32'h10, 3, '0, '0, 0, 0);
        // Partial strobes, write retry
        add_entry(1, 32'h14, 1, 128'h0000_0000_0000_0000_dead_beef_cafe_f00d, 16'h00c3, 1, 0);
        // Read retry
        add_entry(0, 32'h10, 3, '0, '0, 1, 0);
        // Dropped requests while busy
        add_entry(0, 32'h80, 2, '0, '0, 0, 1);
        add_entry(1, 32'h84, 0, 128'h1234_5678, 16'h0006, 0, 1);
        add_entry(0, 32'h80, 2, '0, '0, 0, 0);
        // Top of memory
        add_entry(1, 32'hf8, 1, 128'h0000_0000_0000_0000_a5a5_0f0f_7e7e_8181, 16'h00ff, 0, 0);
        add_entry(0, 32'hf8, 1, '0, '0, 1, 0);
    endtask

    // ========================================================================
    // Bus monitor
    // ========================================================================

    // Falling edge sees the values the next rising edge will take
    always @(negedge clk) begin
        if (arvalid && arready) begin
            hs_addr.push_back(araddr);
            hs_len.push_back(arlen);
            hs_id.push_back(arid);
        end
        if (awvalid && awready) begin
            hs_addr.push_back(awaddr);
            hs_len.push_back(awlen);
            hs_id.push_back(awid);
        end
        if (wvalid && wready) begin
            w_beats++;
            if (wlast) begin
                wlast_cnt++;
            end
            if (wlast != (w_pos == cur_len)) begin
                wlast_bad++;
            end
            w_pos = wlast ? 0 : w_pos + 1;
        end
        if (burst_valid_data) begin
            rd_done_cnt++;
        end
        if (burst_wr_valid) begin
            wr_done_cnt++;
        end
    end

    // ========================================================================
    // Per entry sequence
    // ========================================================================

    task automatic run_entry(int k);
        int attempts;
        int idx;
        attempts = t_inject[k] ? 2 : 1;
        hs_addr.delete();
        hs_len.delete();
        hs_id.delete();
        {w_beats, wlast_cnt, wlast_bad, w_pos, rd_done_cnt, wr_done_cnt} = '0;
        cur_len = int'(t_len[k]);

        // One-cycle request pulse
        base_addr    = t_addr[k];
        burst_len    = t_len[k];
        vlsu_wdata   = t_wdata[k];
        write_strobe = t_wstrb[k];
        ld_req       = !t_store[k];
        st_req       = t_store[k];
        arm_error    = t_inject[k];
        @(posedge clk);
        #DRIVE_DLY;
        {ld_req, st_req, arm_error} = '0;
        check_value("busy", busy, 1);

        // Second request must be dropped
        if (t_dup[k]) begin
            base_addr = t_addr[k] + 32'h20;
            ld_req    = !t_store[k];
            st_req    = t_store[k];
            @(posedge clk);
            #DRIVE_DLY;
            {ld_req, st_req} = '0;
        end

        while (rd_done_cnt + wr_done_cnt == 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        #DRIVE_DLY;

        check_value("busy", busy, 0);
        check_value("address handshakes", hs_addr.size(), attempts);
        foreach (hs_addr[i]) begin
            check_value("handshake addr", hs_addr[i], t_addr[k]);
            check_value("handshake len", hs_len[i], t_len[k]);
            check_value("handshake id", hs_id[i], exp_id);
        end
        check_value("burst_valid_data pulses", rd_done_cnt, !t_store[k]);
        check_value("burst_wr_valid pulses", wr_done_cnt, t_store[k]);

        idx = shadow_index(t_addr[k]);
        if (t_store[k]) begin
            check_value("W beats", w_beats, attempts * (cur_len + 1));
            check_value("wlast beats", wlast_cnt, attempts);
            check_value("misplaced wlast", wlast_bad, 0);
            // Strobe-masked merge into the shadow
            for (int i = 0; i <= cur_len; i++) begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (t_wstrb[k][i*STRB_W + b]) begin
                        shadow[(idx + i) % MEM_WORDS][8*b +: 8] =
                            t_wdata[k][i*DATA_W + 8*b +: 8];
                    end
                end
            end
        end else begin
            for (int i = 0; i <= cur_len; i++) begin
                check_value($sformatf("burst_rdata word %0d", i),
                            burst_rdata[i*DATA_W +: DATA_W],
                            shadow[(idx + i) % MEM_WORDS]);
            end
        end
        exp_id = exp_id + 1'b1;
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================

    initial begin
        {reset, ld_req, st_req, arm_error} = '0;
        base_addr    = '0;
        burst_len    = '0;
        vlsu_wdata   = '0;
        write_strobe = '0;
        errors = 0;
        checks = 0;
        exp_id = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i]    = fill_word(i);
            u_mem.mem[i] = fill_word(i);
        end
        load_table();

        repeat (8) @(posedge clk);
        #DRIVE_DLY;
        reset = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;

        // Quiet bus before the first request
        check_value("arvalid", arvalid, 0);
        check_value("awvalid", awvalid, 0);
        check_value("wvalid", wvalid, 0);
        check_value("rready", rready, 0);
        check_value("bready", bready, 0);
        check_value("busy", busy, 0);
        check_value("burst_valid_data", burst_valid_data, 0);
        check_value("burst_wr_valid", burst_wr_valid, 0);

        for (int k = 0; k < n_entries; k++) begin
            run_entry(k);
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, a burst never completed", cycle_cnt);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/axi_mem_model.sv ====
/*
 * AXI4 slave memory model for the burst master testbench
 * Word memory with strobe merge, LFSR ready/valid delays, one-shot SLVERR
 */
`timescale 1ns/1ns
`default_nettype none

module axi_mem_model import axi_burst_pkg::*; #(
    parameter int MEM_WORDS = 64
) (
    input  wire        clk,
    input  wire        reset,
    // Next response of any kind comes back as SLVERR
    input  wire        arm_error,
    // AR and R channels
    input  wire        arvalid,
    output logic       arready,
    input  axi_id_t    arid,
    input  addr_t      araddr,
    input  axi_len_t   arlen,
    output logic       rvalid,
    input  wire        rready,
    output axi_id_t    rid,
    output data_t      rdata,
    output axi_resp_t  rresp,
    output logic       rlast,
    // AW, W and B channels
    input  wire        awvalid,
    output logic       awready,
    input  axi_id_t    awid,
    input  addr_t      awaddr,
    input  wire        wvalid,
    output logic       wready,
    input  data_t      wdata,
    input  strb_t      wstrb,
    input  wire        wlast,
    output logic       bvalid,
    input  wire        bready,
    output axi_id_t    bid,
    output axi_resp_t  bresp
);

    localparam int          DRIVE_DLY = 2;
    localparam logic [31:0] LFSR_SEED = 32'h9d92_74d8;
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    // Preloaded by the testbench through the hierarchy
    data_t       mem [MEM_WORDS];
    logic [31:0] lfsr_state;
    logic        err_armed;

    // Channel events seen in the cycle before the edge
    logic     ar_fire, r_fire, aw_fire, w_fire, b_fire;
    addr_t    ar_addr_s, aw_addr_s;
    axi_len_t ar_len_s;
    axi_id_t  ar_id_s, aw_id_s;
    data_t    w_data_s;
    strb_t    w_strb_s;
    logic     w_last_s;
    logic     reset_s;

    // Burst bookkeeping
    logic     rd_active, wr_active, b_pending;
    int       rd_base, rd_beat, wr_base, wr_beat;
    axi_len_t rd_len;
    axi_id_t  rd_id, wr_id;

    // One LFSR step per random bit
    function automatic logic take_bit();
        logic lsb;
        lsb = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) begin
            lfsr_state = lfsr_state ^ LFSR_TAPS;
        end
        return lsb;
    endfunction

    function automatic int word_index(addr_t a);
        return (a >> 2) % MEM_WORDS;
    endfunction

    task automatic clear_all();
        {arready, rvalid, rlast, awready, wready, bvalid} = '0;
        rid = '0;
        rdata = '0;
        rresp = RESP_OKAY;
        bid = '0;
        bresp = RESP_OKAY;
        {rd_active, wr_active, b_pending, err_armed} = '0;
        rd_beat = 0;
        wr_beat = 0;
    endtask

    // ========================================================================
    // Read side
    // ========================================================================

    task automatic read_step();
        if (ar_fire) begin
            rd_active = 1'b1;
            rd_base   = word_index(ar_addr_s);
            rd_len    = ar_len_s;
            rd_id     = ar_id_s;
            rd_beat   = 0;
        end
        if (r_fire) begin
            rvalid = 1'b0;
            rlast  = 1'b0;
            if (rd_beat == int'(rd_len)) begin
                rd_active = 1'b0;
            end else begin
                rd_beat++;
            end
        end
        // Back to back beats allowed
        if (rd_active && !rvalid && take_bit()) begin
            rvalid = 1'b1;
            rid    = rd_id;
            rdata  = mem[(rd_base + rd_beat) % MEM_WORDS];
            rlast  = (rd_beat == int'(rd_len));
            rresp  = err_armed ? RESP_SLVERR : RESP_OKAY;
            err_armed = 1'b0;
        end
        arready = rd_active ? 1'b0 : take_bit();
    endtask

    // ========================================================================
    // Write side
    // ========================================================================

    task automatic write_step();
        int idx;
        if (aw_fire) begin
            wr_active = 1'b1;
            wr_base   = word_index(aw_addr_s);
            wr_id     = aw_id_s;
            wr_beat   = 0;
        end
        if (w_fire) begin
            idx = (wr_base + wr_beat) % MEM_WORDS;
            for (int b = 0; b < STRB_W; b++) begin
                if (w_strb_s[b]) begin
                    mem[idx][8*b +: 8] = w_data_s[8*b +: 8];
                end
            end
            wr_beat++;
            if (w_last_s) begin
                b_pending = 1'b1;
            end
        end
        if (b_fire) begin
            bvalid    = 1'b0;
            b_pending = 1'b0;
            wr_active = 1'b0;
        end
        if (b_pending && !bvalid && take_bit()) begin
            bvalid = 1'b1;
            bid    = wr_id;
            bresp  = err_armed ? RESP_SLVERR : RESP_OKAY;
            err_armed = 1'b0;
        end
        wready  = (wr_active && !b_pending) ? take_bit() : 1'b0;
        awready = wr_active ? 1'b0 : take_bit();
    endtask

    // Sample at the falling edge, drive shortly after the rising edge
    initial begin
        lfsr_state = LFSR_SEED;
        clear_all();
        forever begin
            @(negedge clk);
            ar_fire   = arvalid && arready;
            r_fire    = rvalid && rready;
            aw_fire   = awvalid && awready;
            w_fire    = wvalid && wready;
            b_fire    = bvalid && bready;
            ar_addr_s = araddr;
            ar_len_s  = arlen;
            ar_id_s   = arid;
            aw_addr_s = awaddr;
            aw_id_s   = awid;
            w_data_s  = wdata;
            w_strb_s  = wstrb;
            w_last_s  = wlast;
            reset_s   = reset;
            if (arm_error) begin
                err_armed = 1'b1;
            end
            @(posedge clk);
            #DRIVE_DLY;
            if (!reset_s) begin
                clear_all();
            end else begin
                read_step();
                write_step();
            end
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/axi_burst_pkg.sv
design/burst_cmd_if.sv
design/burst_request_capture.sv
design/axi_read_engine.sv
design/axi_write_engine.sv
design/axi_burst_master.sv
verification/axi_mem_model.sv
verification/axi_burst_master_tb.sv
